// File: rename_pkg.sv
/* shared widths, sizes and reset values for the rename subsystem
   arch reg 31 is the zero register and is never renamed */
package rename_pkg;

  localparam int num_arch   = 32;
  localparam int num_phys   = 64;
  localparam int num_rob    = 16;
  localparam int free_depth = num_phys - num_arch;  // tags unbound at reset

  typedef logic [4:0] arch_reg_t;    // architectural reg number
  typedef logic [5:0] phys_tag_t;    // physical reg tag
  typedef logic [3:0] rob_idx_t;     // rob slot
  typedef logic [6:0] map_entry_t;   // {tag, ready}, ready is bit 0

  localparam arch_reg_t zero_reg = 5'd31;

  localparam int rob_cnt_w  = 5;  // occupancy 0..16
  localparam int free_ptr_w = 6;  // free list index plus wrap bit

  // reset values
  localparam phys_tag_t zero_tag       = phys_tag_t'(zero_reg);  // tag of the zero reg
  localparam phys_tag_t first_free_tag = phys_tag_t'(num_arch);  // free list starts at 32

  typedef enum logic {
    run,      // normal renaming
    recover   // one cycle after a rollback
  } ctrl_state_t;

endpackage

// File: rename_control.sv
/* hazard check, rob pointers and occupancy, run/recover fsm
   rollback to a slot that is not in flight is ignored */
module rename_control (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_req,
  input  rename_pkg::arch_reg_t reg_dest,
  input  logic                  retire_req,
  input  logic                  rollback_req,
  input  rename_pkg::rob_idx_t  rollback_idx,
  input  logic                  free_empty,
  output logic                  dispatch_ok,
  output logic                  dispatch_en,
  output logic                  alloc_en,
  output logic                  retire_en,
  output logic                  rollback_en,
  output rename_pkg::rob_idx_t  rob_tail,
  output rename_pkg::rob_idx_t  rob_head
);

  rename_pkg::ctrl_state_t            state_q;
  rename_pkg::rob_idx_t               head_q;
  rename_pkg::rob_idx_t               tail_q;
  rename_pkg::rob_idx_t               roll_ofs;
  logic [rename_pkg::rob_cnt_w-1:0]   count_q;
  logic [rename_pkg::rob_cnt_w-1:0]   count_roll;
  logic                               rob_full;
  logic                               rob_empty;
  logic                               dest_zero;

  assign rob_full  = (count_q == rename_pkg::rob_cnt_w'(rename_pkg::num_rob));
  assign rob_empty = (count_q == '0);
  assign dest_zero = (reg_dest == rename_pkg::zero_reg);  // needs no free tag

  assign dispatch_ok = dispatch_req && (state_q == rename_pkg::run) && !rob_full
                       && (!free_empty || dest_zero);

  // age of the rollback target, 0 is the oldest
  assign roll_ofs    = rollback_idx - head_q;
  assign rollback_en = rollback_req && ({1'b0, roll_ofs} < count_q);
  assign dispatch_en = dispatch_ok && !rollback_en;  // rollback wins
  assign alloc_en    = dispatch_en && !dest_zero;
  assign retire_en   = retire_req && !rob_empty;

  // slots head..k survive, minus one if head retires now
  assign count_roll = {1'b0, roll_ofs} + 5'd1 - {4'd0, retire_en};

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= rename_pkg::run;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (retire_en) begin
        head_q <= head_q + 1'b1;
      end
      if (rollback_en) begin
        tail_q  <= rollback_idx + 1'b1;
        count_q <= count_roll;
      end else begin
        if (dispatch_en) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + {4'd0, dispatch_en} - {4'd0, retire_en};
      end
      case (state_q)
        rename_pkg::run: begin
          if (rollback_en) state_q <= rename_pkg::recover;
        end
        rename_pkg::recover: begin
          if (!rollback_en) state_q <= rename_pkg::run;  // back-to-back rollback stays
        end
        default: state_q <= rename_pkg::run;
      endcase
    end
  end

  assign rob_tail = tail_q;
  assign rob_head = head_q;

  count_in_range: assert property (@(posedge clock) disable iff (reset)
    count_q <= rename_pkg::rob_cnt_w'(rename_pkg::num_rob));
  // equal pointers mean an empty or a full rob
  no_retire_empty: assert property (@(posedge clock) disable iff (reset)
    retire_en |-> (head_q != tail_q) || rob_full);

endmodule

// File: map_table.sv
/* speculative map with ready bits and one checkpoint per rob slot
   checkpoints are only valid for in-flight slots; zero reg reads as tag 31 ready */
module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  logic                  alloc_en,
  input  rename_pkg::arch_reg_t reg_dest,
  input  rename_pkg::arch_reg_t reg_a,
  input  rename_pkg::arch_reg_t reg_b,
  input  rename_pkg::phys_tag_t t_new,
  input  rename_pkg::rob_idx_t  rob_tail,
  input  logic                  cdb_en,
  input  rename_pkg::arch_reg_t cdb_dest,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t t_old,
  output rename_pkg::phys_tag_t t1,
  output logic                  t1_ready,
  output rename_pkg::phys_tag_t t2,
  output logic                  t2_ready
);

  localparam rename_pkg::map_entry_t zero_entry = {rename_pkg::zero_tag, 1'b1};

  rename_pkg::map_entry_t map_q  [rename_pkg::num_arch];  // live speculative map
  rename_pkg::map_entry_t map_d  [rename_pkg::num_arch];
  rename_pkg::map_entry_t ckpt_q [rename_pkg::num_rob][rename_pkg::num_arch];
  rename_pkg::map_entry_t ckpt_d [rename_pkg::num_rob][rename_pkg::num_arch];
  rename_pkg::map_entry_t ent_a;
  rename_pkg::map_entry_t ent_b;

  always_comb begin
    // base: restored checkpoint or current map
    if (rollback_en) begin
      map_d = ckpt_q[rollback_idx];
    end else begin
      map_d = map_q;
    end
    // completion only marks the entry that still holds the tag
    if (cdb_en && map_d[cdb_dest][6:1] == cdb_tag) begin
      map_d[cdb_dest][0] = 1'b1;
    end
    if (alloc_en) begin
      map_d[reg_dest] = {t_new, 1'b0};  // new tag, not ready yet
    end

    ckpt_d = ckpt_q;
    if (cdb_en) begin
      for (int s = 0; s < rename_pkg::num_rob; s++) begin
        if (ckpt_q[s][cdb_dest][6:1] == cdb_tag) begin
          ckpt_d[s][cdb_dest][0] = 1'b1;  // keep saved ready bits current
        end
      end
    end
    // snapshot of the map right after this dispatch, zero reg too
    if (dispatch_en) begin
      ckpt_d[rob_tail] = map_d;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::num_arch; i++) begin
        map_q[i] <= {rename_pkg::phys_tag_t'(i), 1'b1};  // identity map, all ready
      end
    end else begin
      map_q <= map_d;
    end
  end

  always_ff @(posedge clock) begin
    ckpt_q <= ckpt_d;
  end

  // lookups see pre-edge state only
  assign ent_a = (reg_a == rename_pkg::zero_reg) ? zero_entry : map_q[reg_a];
  assign ent_b = (reg_b == rename_pkg::zero_reg) ? zero_entry : map_q[reg_b];

  assign t1       = ent_a[6:1];
  assign t1_ready = ent_a[0];
  assign t2       = ent_b[6:1];
  assign t2_ready = ent_b[0];
  assign t_old    = (reg_dest == rename_pkg::zero_reg) ? rename_pkg::zero_tag
                                                       : map_q[reg_dest][6:1];

  // control must never rename the zero reg
  no_zero_alloc: assert property (@(posedge clock) disable iff (reset)
    alloc_en |-> reg_dest != rename_pkg::zero_reg);

endmodule

// File: free_list.sv
/* circular queue of free tags, seeded with 32..63 at reset
   head snapshots per rob slot are only valid for in-flight slots */
module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  logic                  alloc_en,
  input  rename_pkg::rob_idx_t  rob_tail,
  input  logic                  retire_en,
  input  logic                  head_alloc,
  input  rename_pkg::phys_tag_t head_told,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t t_new,
  output logic                  empty
);

  rename_pkg::phys_tag_t fifo_mem [rename_pkg::free_depth];
  logic [rename_pkg::free_ptr_w-1:0] head_q;     // msb is the wrap bit
  logic [rename_pkg::free_ptr_w-1:0] tail_q;
  logic [rename_pkg::free_ptr_w-1:0] head_inc;
  logic [rename_pkg::free_ptr_w-1:0] head_snap [rename_pkg::num_rob];
  logic                              push;
  logic                              full;

  assign head_inc = head_q + 1'b1;
  assign push     = retire_en && head_alloc;  // only allocating slots give a tag back
  assign empty    = (head_q == tail_q);
  assign full     = (head_q[4:0] == tail_q[4:0]) && (head_q[5] != tail_q[5]);

  // zero reg dispatch or idle cycle shows tag 31
  assign t_new = alloc_en ? fifo_mem[head_q[4:0]] : rename_pkg::zero_tag;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= 6'b100000;  // one lap ahead, queue full
      for (int i = 0; i < rename_pkg::free_depth; i++) begin
        fifo_mem[i] <= rename_pkg::first_free_tag + rename_pkg::phys_tag_t'(i);
      end
    end else begin
      if (rollback_en) begin
        head_q <= head_snap[rollback_idx];  // squashed tags come back
      end else if (alloc_en) begin
        head_q <= head_inc;
      end
      if (push) begin
        fifo_mem[tail_q[4:0]] <= head_told;
        tail_q                <= tail_q + 1'b1;
      end
    end
  end

  // head after this slot's allocation, also for zero reg dispatch
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      head_snap[rob_tail] <= alloc_en ? head_inc : head_q;
    end
  end

  // more frees than tags would mean a tag was freed twice
  no_push_full: assert property (@(posedge clock) disable iff (reset)
    push |-> !full);

endmodule

// File: rob_tag_store.sv
/* tag fields of the rob, written at the tail and read at the head
   slots are read only after a dispatch has written them */
module rob_tag_store (
  input  logic                  clock,
  input  logic                  dispatch_en,
  input  logic                  alloc_en,
  input  rename_pkg::rob_idx_t  rob_tail,
  input  rename_pkg::phys_tag_t t_new,
  input  rename_pkg::phys_tag_t t_old,
  input  rename_pkg::rob_idx_t  rob_head,
  output rename_pkg::phys_tag_t head_told,
  output logic                  head_alloc
);

  rename_pkg::phys_tag_t tnew_mem  [rename_pkg::num_rob];
  rename_pkg::phys_tag_t told_mem  [rename_pkg::num_rob];
  logic                  alloc_mem [rename_pkg::num_rob];  // slot took a free tag

  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      tnew_mem[rob_tail]  <= t_new;
      told_mem[rob_tail]  <= t_old;
      alloc_mem[rob_tail] <= alloc_en;
    end
  end

  // oldest slot, feeds retire
  assign head_told  = told_mem[rob_head];
  assign head_alloc = alloc_mem[rob_head];

  // a renamed slot must never free the tag it was given
  told_not_tnew: assert property (@(posedge clock)
    head_alloc |-> tnew_mem[rob_head] != head_told);

endmodule

// File: rename_top.sv
/* rename subsystem top, one instruction per cycle
   dispatch, completion, retire and rollback are single-cycle strobes */
module rename_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_req,
  input  rename_pkg::arch_reg_t reg_dest,
  input  rename_pkg::arch_reg_t reg_a,
  input  rename_pkg::arch_reg_t reg_b,
  input  logic                  cdb_en,
  input  rename_pkg::arch_reg_t cdb_dest,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  retire_req,
  input  logic                  rollback_req,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output logic                  dispatch_ok,
  output rename_pkg::phys_tag_t t_new,
  output rename_pkg::phys_tag_t t_old,
  output rename_pkg::phys_tag_t t1,
  output logic                  t1_ready,
  output rename_pkg::phys_tag_t t2,
  output logic                  t2_ready,
  output rename_pkg::rob_idx_t  rob_tail,
  output rename_pkg::phys_tag_t retired_tag,
  output logic                  retired_valid
);

  logic                  dispatch_en;
  logic                  alloc_en;
  logic                  retire_en;
  logic                  rollback_en;
  logic                  free_empty;
  logic                  head_alloc;
  rename_pkg::rob_idx_t  rob_head;
  rename_pkg::phys_tag_t head_told;

  rename_control rename_control_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_req (dispatch_req),
    .reg_dest     (reg_dest),
    .retire_req   (retire_req),
    .rollback_req (rollback_req),
    .rollback_idx (rollback_idx),
    .free_empty   (free_empty),
    .dispatch_ok  (dispatch_ok),
    .dispatch_en  (dispatch_en),
    .alloc_en     (alloc_en),
    .retire_en    (retire_en),
    .rollback_en  (rollback_en),
    .rob_tail     (rob_tail),
    .rob_head     (rob_head)
  );

  map_table map_table_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_en),
    .alloc_en     (alloc_en),
    .reg_dest     (reg_dest),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .t_new        (t_new),
    .rob_tail     (rob_tail),
    .cdb_en       (cdb_en),
    .cdb_dest     (cdb_dest),
    .cdb_tag      (cdb_tag),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .t_old        (t_old),
    .t1           (t1),
    .t1_ready     (t1_ready),
    .t2           (t2),
    .t2_ready     (t2_ready)
  );

  free_list free_list_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_en),
    .alloc_en     (alloc_en),
    .rob_tail     (rob_tail),
    .retire_en    (retire_en),
    .head_alloc   (head_alloc),
    .head_told    (head_told),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .t_new        (t_new),
    .empty        (free_empty)
  );

  rob_tag_store rob_tag_store_inst (
    .clock       (clock),
    .dispatch_en (dispatch_en),
    .alloc_en    (alloc_en),
    .rob_tail    (rob_tail),
    .t_new       (t_new),
    .t_old       (t_old),
    .rob_head    (rob_head),
    .head_told   (head_told),
    .head_alloc  (head_alloc)
  );

  // freed tag is visible in the retire cycle itself
  assign retired_valid = retire_en && head_alloc;
  assign retired_tag   = head_told;

endmodule

// File: tb_clock_gen.sv
/* testbench clock, period 100, starts low
   reset is high for the first 2 rising edges and drops on a falling edge */
module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period = 50;

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);  // two reset cycles
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// File: rename_tb.sv
/* reads rename_stimulus.txt, one line per cycle, 10 input fields then 10 expected outputs
   inputs change on the falling edge, outputs are checked 10 units before the rising edge */
module rename_tb;

  localparam int num_fields  = 10;  // fields per half of a line
  localparam int check_delay = 40;  // falling edge to check point
  localparam int spare_cycles = 20;  // reset plus margin

  logic                  clock;
  logic                  reset;
  logic                  dispatch_req;
  rename_pkg::arch_reg_t reg_dest;
  rename_pkg::arch_reg_t reg_a;
  rename_pkg::arch_reg_t reg_b;
  logic                  cdb_en;
  rename_pkg::arch_reg_t cdb_dest;
  rename_pkg::phys_tag_t cdb_tag;
  logic                  retire_req;
  logic                  rollback_req;
  rename_pkg::rob_idx_t  rollback_idx;
  logic                  dispatch_ok;
  rename_pkg::phys_tag_t t_new;
  rename_pkg::phys_tag_t t_old;
  rename_pkg::phys_tag_t t1;
  logic                  t1_ready;
  rename_pkg::phys_tag_t t2;
  logic                  t2_ready;
  rename_pkg::rob_idx_t  rob_tail;
  rename_pkg::phys_tag_t retired_tag;
  logic                  retired_valid;

  rename_pkg::ctrl_state_t dut_state;  // shown in error lines

  string lines_q[$];               // data lines, comments dropped
  int    drive_val [num_fields];
  int    want_val  [num_fields];
  int    got_val   [num_fields];
  int    cycle_count = 0;
  int    cycle_limit = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clock (clock),
    .reset (reset)
  );

  rename_top rename_top_inst (
    .clock         (clock),
    .reset         (reset),
    .dispatch_req  (dispatch_req),
    .reg_dest      (reg_dest),
    .reg_a         (reg_a),
    .reg_b         (reg_b),
    .cdb_en        (cdb_en),
    .cdb_dest      (cdb_dest),
    .cdb_tag       (cdb_tag),
    .retire_req    (retire_req),
    .rollback_req  (rollback_req),
    .rollback_idx  (rollback_idx),
    .dispatch_ok   (dispatch_ok),
    .t_new         (t_new),
    .t_old         (t_old),
    .t1            (t1),
    .t1_ready      (t1_ready),
    .t2            (t2),
    .t2_ready      (t2_ready),
    .rob_tail      (rob_tail),
    .retired_tag   (retired_tag),
    .retired_valid (retired_valid)
  );

  assign dut_state = rename_top_inst.rename_control_inst.state_q;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input int got, input int want);
    if (got != want) begin
      abort_run($sformatf("FAILED at time %0t: %s expected %0d, got %0d (state %s)",
                          $time, name, want, got, dut_state.name()));
    end
  endtask

  // order matches the expected half of a stimulus line
  function automatic string output_name(input int k);
    case (k)
      0:       return "dispatch_ok";
      1:       return "t_new";
      2:       return "t_old";
      3:       return "t1";
      4:       return "t1_ready";
      5:       return "t2";
      6:       return "t2_ready";
      7:       return "rob_tail";
      8:       return "retired_valid";
      default: return "retired_tag";
    endcase
  endfunction

  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen("rename_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open rename_stimulus.txt for reading");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        lines_q.push_back(line);
      end
    end
    $fclose(fd);
    if (lines_q.size() == 0) begin
      abort_run("rename_stimulus.txt holds no stimulus lines");
    end
    cycle_limit = lines_q.size() + spare_cycles;  // one line per cycle
  endtask

  task automatic apply_line(input int n);
    int cnt;
    cnt = $sscanf(lines_q[n], "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                  drive_val[0], drive_val[1], drive_val[2], drive_val[3], drive_val[4],
                  drive_val[5], drive_val[6], drive_val[7], drive_val[8], drive_val[9],
                  want_val[0], want_val[1], want_val[2], want_val[3], want_val[4],
                  want_val[5], want_val[6], want_val[7], want_val[8], want_val[9]);
    if (cnt != 2 * num_fields) begin
      abort_run($sformatf("stimulus line %0d does not hold 20 numbers", n + 1));
    end
    dispatch_req = (drive_val[0] != 0);
    reg_dest     = rename_pkg::arch_reg_t'(drive_val[1]);
    reg_a        = rename_pkg::arch_reg_t'(drive_val[2]);
    reg_b        = rename_pkg::arch_reg_t'(drive_val[3]);
    cdb_en       = (drive_val[4] != 0);
    cdb_dest     = rename_pkg::arch_reg_t'(drive_val[5]);
    cdb_tag      = rename_pkg::phys_tag_t'(drive_val[6]);
    retire_req   = (drive_val[7] != 0);
    rollback_req = (drive_val[8] != 0);
    rollback_idx = rename_pkg::rob_idx_t'(drive_val[9]);
  endtask

  task automatic check_line();
    got_val[0] = int'(dispatch_ok);
    got_val[1] = int'(t_new);
    got_val[2] = int'(t_old);
    got_val[3] = int'(t1);
    got_val[4] = int'(t1_ready);
    got_val[5] = int'(t2);
    got_val[6] = int'(t2_ready);
    got_val[7] = int'(rob_tail);
    got_val[8] = int'(retired_valid);
    got_val[9] = int'(retired_tag);
    for (int k = 0; k < num_fields; k++) begin
      // freed tag only counts while retired_valid is high
      if (k != 9 || want_val[8] != 0) begin
        check_value(output_name(k), got_val[k], want_val[k]);
      end
    end
  endtask

  // hang guard
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    dispatch_req = 1'b0;
    reg_dest     = '0;
    reg_a        = '0;
    reg_b        = '0;
    cdb_en       = 1'b0;
    cdb_dest     = '0;
    cdb_tag      = '0;
    retire_req   = 1'b0;
    rollback_req = 1'b0;
    rollback_idx = '0;
    load_stimulus();
    @(negedge reset);  // lands on a falling edge
    for (int n = 0; n < lines_q.size(); n++) begin
      apply_line(n);
      #check_delay;
      check_line();
      @(negedge clock);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// File: rename_stimulus.txt
# in:  dispatch_req reg_dest reg_a reg_b cdb_en cdb_dest cdb_tag retire_req rollback_req rollback_idx
# out: dispatch_ok t_new t_old t1 t1_ready t2 t2_ready rob_tail retired_valid retired_tag
0  0  5 31  0 0  0  0 0 0    0 31  0  5 1 31 1  0 0  0   # identity map after reset
1  1  2  3  0 0  0  0 0 0    1 32  1  2 1  3 1  0 0  0
1  2  1  1  0 0  0  0 0 0    1 33  2 32 0 32 0  1 0  0
1 31 31  2  0 0  0  0 0 0    1 31 31 31 1 33 0  2 0  0   # zero reg takes a slot only
1  3  1  2  1 1 32  0 0 0    1 34  3 32 0 33 0  3 0  0   # same-cycle completion reads not ready
1  4  1  3  1 2 20  0 0 0    1 35  4 32 1 34 0  4 0  0   # stale tag for reg 2
0  5  2  1  1 2 33  0 0 0    0 31  5 33 0 32 1  5 0  0
1  2  2  4  0 0  0  0 0 0    1 36 33 33 1 35 0  5 0  0
0  0  3  4  1 3 34  0 0 0    0 31  0 34 0 35 0  6 0  0
1  6  3  2  0 0  0  1 1 3    1 31  6 34 1 36 0  6 1  1   # rollback to slot 3 beats dispatch
1  6  4  3  0 0  0  1 0 0    0 31  6  4 1 34 1  4 1  2   # recover cycle, retire still works
1  6  2  1  0 0  0  0 0 0    1 35  6 33 1 32 1  4 0  0
1  7  6  0  0 0  0  0 0 0    1 36  7 35 0  0 1  5 0  0
1  8  7  0  0 0  0  0 0 0    1 37  8 36 0  0 1  6 0  0
1  9  8  0  0 0  0  0 0 0    1 38  9 37 0  0 1  7 0  0
1 10  9  0  0 0  0  0 0 0    1 39 10 38 0  0 1  8 0  0
1 11 10  0  0 0  0  0 0 0    1 40 11 39 0  0 1  9 0  0
1 12 11  0  0 0  0  0 0 0    1 41 12 40 0  0 1 10 0  0
1 13 12  0  0 0  0  0 0 0    1 42 13 41 0  0 1 11 0  0
1 14 13  0  0 0  0  0 0 0    1 43 14 42 0  0 1 12 0  0
1 15 14  0  0 0  0  0 0 0    1 44 15 43 0  0 1 13 0  0
1 16 15  0  0 0  0  0 0 0    1 45 16 44 0  0 1 14 0  0
1 17 16  0  0 0  0  0 0 0    1 46 17 45 0  0 1 15 0  0
1 18 17  0  0 0  0  0 0 0    1 47 18 46 0  0 1  0 0  0
1 19 18  0  0 0  0  0 0 0    1 48 19 47 0  0 1  1 0  0
1 20 19  0  0 0  0  1 0 0    0 31 20 48 0  0 1  2 0  0   # rob full, zero reg slot retires
1 20 19 31  0 0  0  1 0 0    1 49 20 48 0 31 1  2 1  3
1 21 20 31  0 0  0  1 0 0    1 50 21 49 0 31 1  3 1  6
1 22 21 31  0 0  0  1 0 0    1 51 22 50 0 31 1  4 1  7
1 23 22 31  0 0  0  1 0 0    1 52 23 51 0 31 1  5 1  8
1 24 23 31  0 0  0  1 0 0    1 53 24 52 0 31 1  6 1  9
1 25 24 31  0 0  0  1 0 0    1 54 25 53 0 31 1  7 1 10
1 26 25 31  0 0  0  1 0 0    1 55 26 54 0 31 1  8 1 11
1 27 26 31  0 0  0  1 0 0    1 56 27 55 0 31 1  9 1 12
1 28 27 31  0 0  0  1 0 0    1 57 28 56 0 31 1 10 1 13
1 29 28 31  0 0  0  1 0 0    1 58 29 57 0 31 1 11 1 14
1 30 29 31  0 0  0  1 0 0    1 59 30 58 0 31 1 12 1 15
1  0 30 31  0 0  0  1 0 0    1 60  0 59 0 31 1 13 1 16
1  1  0 31  0 0  0  1 0 0    1 61 32 60 0 31 1 14 1 17
1  2  1 31  0 0  0  1 0 0    1 62 33 61 0 31 1 15 1 18
1  3  2 31  0 0  0  1 0 0    1 63 34 62 0 31 1  0 1 19   # last of the initial free tags
1  4  3 31  0 0  0  1 0 0    1  1  4 63 0 31 1  1 1 20   # freed tags come back in order
1  5  4 31  0 0  0  1 0 0    1  2  5  1 0 31 1  2 1 21
1  6  5 31  0 0  0  1 0 0    1  3 35  2 0 31 1  3 1 22
0  0  4  6  1 4  1  0 0 0    0 31 60  1 0  3 0  4 0  0
0  0  4  5  0 0  0  0 0 0    0 31 60  1 1  2 0  4 0  0

// File: sim.f
rename_pkg.sv
rename_control.sv
map_table.sv
free_list.sv
rob_tag_store.sv
rename_top.sv
tb_clock_gen.sv
rename_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the rename testbench with verilator and run it from the project root
# a failing run ends in $fatal, which gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module rename_tb -f sim.f -o rename_sim
./obj_dir/rename_sim
